// ==== common/rename_pkg.sv ====
package rename_pkg;

    // Group and register file sizes
    localparam int RENAME_WIDTH = 2;
    localparam int SRC_NUM = 2;
    localparam int AREG_NUM = 32;
    localparam int AREG_W = 5;
    localparam int PREG_NUM = 64;
    localparam int PREG_W = 6;

    // Free list holds every physical register not mapped at reset
    localparam int FREE_NUM = PREG_NUM - AREG_NUM;
    localparam int FREE_IDX_W = $clog2(FREE_NUM);
    // Extra wrap bit tells full from empty
    localparam int FREE_PTR_W = FREE_IDX_W + 1;

    // Width of a per-group count, 0 up to RENAME_WIDTH
    localparam int COUNT_W = $clog2(RENAME_WIDTH + 1);

    typedef logic [AREG_W-1:0] areg_t;
    typedef logic [PREG_W-1:0] preg_t;

    typedef struct packed {
        logic  valid;
        areg_t rs1;
        areg_t rs2;
        areg_t rd;
        logic  rd_we;
    } rename_op_t;

    typedef struct packed {
        logic  valid;
        logic  rd_we;
        preg_t prs1;
        preg_t prs2;
        preg_t prd;
        preg_t old_prd;
    } renamed_op_t;

    typedef struct packed {
        logic  valid;
        logic  rd_we;
        areg_t rd;
        preg_t prd;
        preg_t old_prd;
    } commit_t;

    // Lane 0 is the oldest operation
    typedef rename_op_t  [RENAME_WIDTH-1:0] rename_group_t;
    typedef renamed_op_t [RENAME_WIDTH-1:0] renamed_group_t;
    typedef commit_t     [RENAME_WIDTH-1:0] commit_group_t;

endpackage

// ==== rename/rename_table.sv ====
`timescale 1ns/10ps

module rename_table import rename_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst,
    input  rename_group_t                         in_group,
    input  logic [RENAME_WIDTH-1:0]               we,
    input  preg_t [RENAME_WIDTH-1:0]              new_prd,
    input  commit_group_t                         commit_group,
    input  logic                                  redirect,
    output preg_t [SRC_NUM-1:0][RENAME_WIDTH-1:0] table_psrc,
    output preg_t [RENAME_WIDTH-1:0]              table_old_prd
);

    preg_t [AREG_NUM-1:0] spec_map;
    preg_t [AREG_NUM-1:0] comm_map;
    preg_t [AREG_NUM-1:0] comm_next;

    // Lookups come straight off the speculative map
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            table_psrc[0][i] = spec_map[in_group[i].rs1];
            table_psrc[1][i] = spec_map[in_group[i].rs2];
            table_old_prd[i] = spec_map[in_group[i].rd];
        end
    end

    // Committed map after this cycle's commits, younger lane last
    always_comb begin
        comm_next = comm_map;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (commit_group[i].valid && commit_group[i].rd_we &&
                commit_group[i].rd != '0) begin
                comm_next[commit_group[i].rd] = commit_group[i].prd;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < AREG_NUM; i++) begin
                comm_map[i] <= preg_t'(i);
            end
        end else begin
            comm_map <= comm_next;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < AREG_NUM; i++) begin
                spec_map[i] <= preg_t'(i);
            end
        end else if (redirect) begin
            // Restore includes commits of the same cycle
            spec_map <= comm_next;
        end else begin
            // Later assignment wins, so the younger lane lands
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (we[i]) begin
                    spec_map[in_group[i].rd] <= new_prd[i];
                end
            end
        end
    end

    // x0 must never be remapped by either path
    x0_map_fixed: assert property (@(posedge clk) disable iff (!rst)
        spec_map[0] == '0 && comm_map[0] == '0);

endmodule

// ==== rename/free_list.sv ====
`timescale 1ns/10ps

module free_list import rename_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [COUNT_W-1:0]       need_num,
    input  logic [COUNT_W-1:0]       alloc_num,
    input  commit_group_t            commit_group,
    input  logic                     redirect,
    output preg_t [RENAME_WIDTH-1:0] alloc_prd,
    output logic                     full
);

    preg_t [FREE_NUM-1:0] fifo_mem;

    logic [FREE_PTR_W-1:0] spec_head;
    logic [FREE_PTR_W-1:0] comm_head;
    logic [FREE_PTR_W-1:0] tail;
    logic [FREE_PTR_W-1:0] free_cnt;
    logic [FREE_PTR_W-1:0] comm_head_next;
    logic [FREE_PTR_W-1:0] rd_ptr [RENAME_WIDTH];
    logic [FREE_PTR_W-1:0] push_ptr [RENAME_WIDTH];
    logic [RENAME_WIDTH-1:0] commit_wr;
    logic [COUNT_W-1:0] commit_num;

    assign free_cnt = tail - spec_head;
    assign full = free_cnt < FREE_PTR_W'(need_num);
    assign comm_head_next = comm_head + FREE_PTR_W'(commit_num);

    // Next free registers in FIFO order
    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            rd_ptr[i] = spec_head + FREE_PTR_W'(i);
            alloc_prd[i] = fifo_mem[rd_ptr[i][FREE_IDX_W-1:0]];
        end
    end

    // Each committing writer returns its old register, packed in lane order
    always_comb begin
        commit_num = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            commit_wr[i] = commit_group[i].valid && commit_group[i].rd_we &&
                           commit_group[i].rd != '0;
            push_ptr[i] = tail + FREE_PTR_W'(commit_num);
            if (commit_wr[i]) begin
                commit_num = commit_num + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < FREE_NUM; i++) begin
                fifo_mem[i] <= preg_t'(AREG_NUM + i);
            end
        end else begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (commit_wr[i]) begin
                    fifo_mem[push_ptr[i][FREE_IDX_W-1:0]] <= commit_group[i].old_prd;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            spec_head <= '0;
            comm_head <= '0;
            tail <= FREE_PTR_W'(FREE_NUM);
        end else begin
            comm_head <= comm_head_next;
            tail <= tail + FREE_PTR_W'(commit_num);
            if (redirect) begin
                spec_head <= comm_head_next;
            end else begin
                spec_head <= spec_head + FREE_PTR_W'(alloc_num);
            end
        end
    end

    free_cnt_bound: assert property (@(posedge clk) disable iff (!rst)
        free_cnt <= FREE_PTR_W'(FREE_NUM));

    // dep_check must not take more than the list offers
    alloc_in_range: assert property (@(posedge clk) disable iff (!rst)
        FREE_PTR_W'(alloc_num) <= free_cnt);

endmodule

// ==== rename/dep_check.sv ====
`timescale 1ns/10ps

module dep_check import rename_pkg::*; (
    input  rename_group_t                         in_group,
    input  preg_t [SRC_NUM-1:0][RENAME_WIDTH-1:0] table_psrc,
    input  preg_t [RENAME_WIDTH-1:0]              table_old_prd,
    input  preg_t [RENAME_WIDTH-1:0]              alloc_prd,
    input  logic                                  full,
    input  logic                                  stall,
    input  logic                                  redirect,
    output logic [COUNT_W-1:0]                    need_num,
    output logic [COUNT_W-1:0]                    alloc_num,
    output logic [RENAME_WIDTH-1:0]               we,
    output preg_t [RENAME_WIDTH-1:0]              new_prd,
    output renamed_group_t                        renamed
);

    logic [RENAME_WIDTH-1:0] wr;
    logic [COUNT_W-1:0] slot [RENAME_WIDTH];
    logic accept;
    preg_t psrc1;
    preg_t psrc2;
    preg_t old_prd;

    assign accept = !redirect && !stall && !full;
    assign alloc_num = accept ? need_num : '0;
    assign we = accept ? wr : '0;

    // Writer lanes take free registers in lane order
    always_comb begin
        need_num = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            wr[i] = in_group[i].valid && in_group[i].rd_we && in_group[i].rd != '0;
            slot[i] = need_num;
            new_prd[i] = wr[i] ? alloc_prd[slot[i]] : '0;
            if (wr[i]) begin
                need_num = need_num + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            psrc1 = (in_group[i].rs1 == '0) ? '0 : table_psrc[0][i];
            psrc2 = (in_group[i].rs2 == '0) ? '0 : table_psrc[1][i];
            old_prd = wr[i] ? table_old_prd[i] : '0;
            // Youngest older writer overrides the table
            for (int j = 0; j < i; j++) begin
                if (wr[j] && in_group[j].rd == in_group[i].rs1) begin
                    psrc1 = new_prd[j];
                end
                if (wr[j] && in_group[j].rd == in_group[i].rs2) begin
                    psrc2 = new_prd[j];
                end
                if (wr[i] && wr[j] && in_group[j].rd == in_group[i].rd) begin
                    old_prd = new_prd[j];
                end
            end
            renamed[i].valid = in_group[i].valid && accept;
            renamed[i].rd_we = wr[i];
            renamed[i].prs1 = psrc1;
            renamed[i].prs2 = psrc2;
            renamed[i].prd = new_prd[i];
            renamed[i].old_prd = old_prd;
        end
    end

endmodule

// ==== rename/rename_out_reg.sv ====
`timescale 1ns/10ps

module rename_out_reg import rename_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  renamed_group_t renamed,
    input  logic           stall,
    input  logic           redirect,
    output renamed_group_t out_group
);

    logic [RENAME_WIDTH-1:0] valid_q;
    logic [RENAME_WIDTH-1:0] rd_we_q;
    renamed_group_t payload_q;

    // Valid and write enable are the only control bits
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            rd_we_q <= '0;
        end else if (redirect) begin
            valid_q <= '0;
            rd_we_q <= '0;
        end else if (!stall) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                valid_q[i] <= renamed[i].valid;
                rd_we_q[i] <= renamed[i].rd_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            payload_q <= renamed;
        end
    end

    always_comb begin
        out_group = payload_q;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            out_group[i].valid = valid_q[i];
            out_group[i].rd_we = rd_we_q[i];
        end
    end

endmodule

// ==== hdl/rename_unit.sv ====
`timescale 1ns/10ps

module rename_unit import rename_pkg::*; (
    input  logic           clk,
    input  logic           rst,
    input  rename_group_t  in_group,
    input  logic           stall,
    input  logic           redirect,
    input  commit_group_t  commit_group,
    output renamed_group_t out_group,
    output logic           full
);

    preg_t [SRC_NUM-1:0][RENAME_WIDTH-1:0] table_psrc;
    preg_t [RENAME_WIDTH-1:0] table_old_prd;
    preg_t [RENAME_WIDTH-1:0] alloc_prd;
    preg_t [RENAME_WIDTH-1:0] new_prd;
    logic [RENAME_WIDTH-1:0] we;
    logic [COUNT_W-1:0] need_num;
    logic [COUNT_W-1:0] alloc_num;
    renamed_group_t renamed;

    rename_table u_rename_table (
        .clk           (clk),
        .rst           (rst),
        .in_group      (in_group),
        .we            (we),
        .new_prd       (new_prd),
        .commit_group  (commit_group),
        .redirect      (redirect),
        .table_psrc    (table_psrc),
        .table_old_prd (table_old_prd)
    );

    free_list u_free_list (
        .clk          (clk),
        .rst          (rst),
        .need_num     (need_num),
        .alloc_num    (alloc_num),
        .commit_group (commit_group),
        .redirect     (redirect),
        .alloc_prd    (alloc_prd),
        .full         (full)
    );

    dep_check u_dep_check (
        .in_group      (in_group),
        .table_psrc    (table_psrc),
        .table_old_prd (table_old_prd),
        .alloc_prd     (alloc_prd),
        .full          (full),
        .stall         (stall),
        .redirect      (redirect),
        .need_num      (need_num),
        .alloc_num     (alloc_num),
        .we            (we),
        .new_prd       (new_prd),
        .renamed       (renamed)
    );

    rename_out_reg u_rename_out_reg (
        .clk       (clk),
        .rst       (rst),
        .renamed   (renamed),
        .stall     (stall),
        .redirect  (redirect),
        .out_group (out_group)
    );

endmodule

// ==== verification/rename_model.svh ====
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// Mirror of both maps and the free FIFO
int m_spec [AREG_NUM];
int m_comm [AREG_NUM];
int m_fifo [FREE_NUM];
int m_spec_head;
int m_comm_head;
int m_tail;
bit m_accept;
renamed_group_t m_out;

// Accepted operations not yet committed, oldest first
commit_t pend_q [$];

function automatic void model_reset();
    for (int i = 0; i < AREG_NUM; i++) begin
        m_spec[i] = i;
        m_comm[i] = i;
    end
    for (int i = 0; i < FREE_NUM; i++) begin
        m_fifo[i] = AREG_NUM + i;
    end
    m_spec_head = 0;
    m_comm_head = 0;
    m_tail = FREE_NUM;
    m_accept = 1'b0;
    m_out = '0;
    pend_q.delete();
endfunction

function automatic bit writes_rd(rename_op_t op);
    return op.valid && op.rd_we && op.rd != '0;
endfunction

function automatic int model_need(rename_group_t grp);
    int n;
    n = 0;
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (writes_rd(grp[i])) begin
            n++;
        end
    end
    return n;
endfunction

function automatic bit model_full(rename_group_t grp);
    return (m_tail - m_spec_head) < model_need(grp);
endfunction

// One clock edge with the inputs present at that edge
function automatic void model_step(rename_group_t grp, logic stl, logic rdr,
                                   commit_group_t cg);
    renamed_group_t ren;
    commit_t c;
    int map [AREG_NUM];
    int k;
    bit acc;
    acc = !rdr && !stl && !model_full(grp);
    map = m_spec;
    k = 0;
    // Working copy of the map gives the in-group bypass in lane order
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        ren[i] = '0;
        ren[i].valid = grp[i].valid && acc;
        ren[i].rd_we = writes_rd(grp[i]);
        ren[i].prs1 = (grp[i].rs1 == '0) ? '0 : preg_t'(map[grp[i].rs1]);
        ren[i].prs2 = (grp[i].rs2 == '0) ? '0 : preg_t'(map[grp[i].rs2]);
        if (writes_rd(grp[i])) begin
            ren[i].old_prd = preg_t'(map[grp[i].rd]);
            ren[i].prd = preg_t'(m_fifo[(m_spec_head + k) % FREE_NUM]);
            map[grp[i].rd] = int'(ren[i].prd);
            k++;
        end
    end
    for (int i = 0; i < RENAME_WIDTH; i++) begin
        if (cg[i].valid && cg[i].rd_we && cg[i].rd != '0) begin
            m_comm[cg[i].rd] = int'(cg[i].prd);
            m_fifo[m_tail % FREE_NUM] = int'(cg[i].old_prd);
            m_tail++;
            m_comm_head++;
        end
    end
    if (rdr) begin
        m_spec = m_comm;
        m_spec_head = m_comm_head;
        pend_q.delete();
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            m_out[i].valid = 1'b0;
            m_out[i].rd_we = 1'b0;
        end
    end else begin
        if (acc) begin
            m_spec = map;
            m_spec_head += k;
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                if (grp[i].valid) begin
                    c.valid = 1'b1;
                    c.rd_we = ren[i].rd_we;
                    c.rd = grp[i].rd;
                    c.prd = ren[i].prd;
                    c.old_prd = ren[i].old_prd;
                    pend_q.push_back(c);
                end
            end
        end
        if (!stl) begin
            m_out = ren;
        end
    end
    m_accept = acc;
endfunction

`endif

// ==== verification/tb_rename.sv ====
`timescale 1ns/10ps

module tb_rename import rename_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT_NS = (RESET_CYCLES + NUM_CYCLES + 100) * CLK_PERIOD;

    logic clk = 1'b0;
    logic rst;
    rename_group_t in_group;
    logic stall;
    logic redirect;
    commit_group_t commit_group;
    renamed_group_t out_group;
    logic full;

    int unsigned rng_state = 2;
    int full_cnt = 0;
    int redirect_cnt = 0;

    `include "rename_model.svh"

    rename_unit uut (
        .clk          (clk),
        .rst          (rst),
        .in_group     (in_group),
        .stall        (stall),
        .redirect     (redirect),
        .commit_group (commit_group),
        .out_group    (out_group),
        .full         (full)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic stop_on_fail();
        $display("RESULT: FAIL");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_val(string name, int got, int exp);
        assert (got == exp) else begin
            $display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
            stop_on_fail();
        end
    endtask

    task automatic check_outputs();
        check_val("full", int'(full), int'(model_full(in_group)));
        if (full) begin
            full_cnt++;
        end
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            check_val($sformatf("out_group[%0d].valid", i), int'(out_group[i].valid),
                      int'(m_out[i].valid));
            if (m_out[i].valid) begin
                check_val($sformatf("out_group[%0d].rd_we", i), int'(out_group[i].rd_we),
                          int'(m_out[i].rd_we));
                check_val($sformatf("out_group[%0d].prs1", i), int'(out_group[i].prs1),
                          int'(m_out[i].prs1));
                check_val($sformatf("out_group[%0d].prs2", i), int'(out_group[i].prs2),
                          int'(m_out[i].prs2));
                if (m_out[i].rd_we) begin
                    check_val($sformatf("out_group[%0d].prd", i), int'(out_group[i].prd),
                              int'(m_out[i].prd));
                    check_val($sformatf("out_group[%0d].old_prd", i),
                              int'(out_group[i].old_prd), int'(m_out[i].old_prd));
                end
            end
        end
    endtask

    task automatic drive_next(int cyc);
        rename_group_t grp;
        commit_group_t cg;
        int n;
        bit drain;
        bit busy;
        // Commits held back in this window so the list runs dry
        drain = (cyc % 500) >= 350;
        busy = 1'b0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            busy = busy | in_group[i].valid;
        end
        grp = in_group;
        // Same group stays offered until accepted
        if (m_accept || !busy) begin
            for (int i = 0; i < RENAME_WIDTH; i++) begin
                grp[i].valid = (next_rand() % 4) != 0;
                grp[i].rs1 = areg_t'(next_rand() % 8);
                grp[i].rs2 = areg_t'(next_rand() % 8);
                grp[i].rd = areg_t'(next_rand() % 8);
                grp[i].rd_we = (next_rand() % 4) != 0;
            end
        end
        in_group <= grp;
        stall <= (next_rand() % 6) == 0;
        if (!redirect && !drain && (next_rand() % 40) == 0) begin
            redirect <= 1'b1;
            redirect_cnt++;
        end else begin
            redirect <= 1'b0;
        end
        n = drain ? 0 : int'(next_rand() % 3);
        cg = '0;
        for (int i = 0; i < RENAME_WIDTH; i++) begin
            if (i < n && pend_q.size() > 0) begin
                cg[i] = pend_q.pop_front();
            end
        end
        commit_group <= cg;
    endtask

    initial begin
        rst = 1'b0;
        in_group = '0;
        stall = 1'b0;
        redirect = 1'b0;
        commit_group = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            model_step(in_group, stall, redirect, commit_group);
            drive_next(cyc);
            // Outputs compared mid-cycle once everything has settled
            @(negedge clk);
            check_outputs();
        end
        if (full_cnt > 0 && redirect_cnt > 0 && m_comm_head > FREE_NUM) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("Stimulus missed a goal: %0d full cycles, %0d redirects, %0d commits",
                     full_cnt, redirect_cnt, m_comm_head);
            stop_on_fail();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        stop_on_fail();
    end

endmodule

// ==== verilog.f ====
+incdir+verification
common/rename_pkg.sv
rename/rename_table.sv
rename/free_list.sv
rename/dep_check.sv
rename/rename_out_reg.sv
hdl/rename_unit.sv
verification/tb_rename.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module tb_rename -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rename)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
fi
exit 1
